/* Makefile */
# verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "sim: failure reported in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "sim: run ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+logic
logic/icache_pkg.sv
logic/icache_way.sv
logic/icache_lru.sv
logic/icache_ctrl.sv
logic/icache_top.sv
testbench/icache_l2_model.sv
testbench/icache_tb.sv

/* logic/icache_consts.svh */
/*
 two-way instruction cache constants
 address map field widths, geometry and way select codes
*/
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// address split: tag | index | word offset | byte
`define IC_TAG_W        20      // addr[31:12]
`define IC_INDEX_W      8       // addr[11:4]

// geometry
`define IC_SETS         256     // 2**IC_INDEX_W
`define IC_LINE_WORDS   4       // 16 byte line

// way select codes
// shared by victim choice, lru update and fill strobes
`define IC_WAY0         1'b0
`define IC_WAY1         1'b1

// invalid way 0 beats invalid way 1 beats lru
// the lru bit always names the way to replace next



`endif

/* logic/icache_ctrl.sv */
/*
 instruction cache controller
 tag compare, word select, victim choice and the miss fsm toward next level
*/
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    // fetch side
    input  word_t  fetch_addr,      // stable while miss_stall
    output word_t  fetch_data,
    output logic   data_rdy,        // hit this cycle
    output logic   miss_stall,
    // next level
    input  logic   l2_busy,
    output logic   l2_req,          // one cycle pulse
    output word_t  l2_addr,         // line address
    input  logic   l2_rdy,          // strobe with l2_line
    input  line_t  l2_line,
    // ways
    output index_t index,
    output tag_t   fill_tag,
    output line_t  fill_line,
    output logic   fill0,
    output logic   fill1,
    input  logic   valid0,
    input  logic   valid1,
    input  tag_t   tag0,
    input  tag_t   tag1,
    input  line_t  line0,
    input  line_t  line1,
    // lru array
    input  logic   lru,
    output logic   lru_upd,
    output logic   lru_way
);

    ic_state_t state, next_state;
    tag_t      addr_tag;
    offset_t   offset;
    logic      hit0, hit1, hit;
    line_t     hit_line;
    logic      victim;              // way to fill, combinational
    logic      victim_q;            // frozen at request
    line_t     line_q;              // captured fill data

    // address fields
    assign addr_tag = fetch_addr[31:32-`IC_TAG_W];
    assign index    = fetch_addr[`IC_INDEX_W+3:4];
    assign offset   = fetch_addr[3:2];

    // line address, fetch_addr held until the fill
    assign l2_addr  = {fetch_addr[31:4], 4'b0000};

    // tag compare
    assign hit0 = valid0 && (tag0 == addr_tag);
    assign hit1 = valid1 && (tag1 == addr_tag);
    assign hit  = hit0 || hit1;

    // word select from the hitting way
    assign hit_line = hit1 ? line1 : line0;

    always_comb begin
        fetch_data = hit_line[31:0];
        for (int w = 0; w < `IC_LINE_WORDS; w++) begin
            if (offset == w) begin
                fetch_data = hit_line[w*32 +: 32];
            end
        end
    end

    // victim: empty way 0, then empty way 1, then lru
    always_comb begin
        if (!valid0) begin
            victim = `IC_WAY0;
        end else if (!valid1) begin
            victim = `IC_WAY1;
        end else begin
            victim = lru;
        end
    end

    // fill port
    assign fill_tag  = addr_tag;
    assign fill_line = line_q;

    // miss fsm, outputs decoded from state
    always_comb begin
        next_state = state;
        data_rdy   = 1'b0;
        miss_stall = 1'b0;
        l2_req     = 1'b0;
        fill0      = 1'b0;
        fill1      = 1'b0;
        lru_upd    = 1'b0;
        lru_way    = `IC_WAY0;
        case (state)
            ic_idle: begin
                next_state = ic_lookup;     // arrays settle after reset
            end
            ic_lookup: begin
                if (hit) begin
                    data_rdy = 1'b1;        // zero latency
                    lru_upd  = 1'b1;
                    lru_way  = hit1 ? `IC_WAY1 : `IC_WAY0;
                end else begin
                    miss_stall = 1'b1;
                    if (!l2_busy) begin
                        l2_req     = 1'b1;
                        next_state = ic_wait_fill;
                    end else begin
                        next_state = ic_wait_busy;
                    end
                end
            end
            ic_wait_busy: begin
                miss_stall = 1'b1;
                if (!l2_busy) begin
                    l2_req     = 1'b1;
                    next_state = ic_wait_fill;
                end
            end
            ic_wait_fill: begin
                miss_stall = 1'b1;
                if (l2_rdy) begin
                    next_state = ic_fill;
                end
            end
            ic_fill: begin
                miss_stall = 1'b1;          // drops with data_rdy on retry
                fill0      = (victim_q == `IC_WAY0);
                fill1      = (victim_q == `IC_WAY1);
                lru_upd    = 1'b1;
                lru_way    = victim_q;
                next_state = ic_lookup;
            end
            default: begin
                next_state = ic_idle;
            end
        endcase
    end

    // state and victim
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ic_idle;
            victim_q <= `IC_WAY0;
        end else begin
            state <= next_state;
            if (l2_req) begin
                victim_q <= victim;         // fill target fixed from here
            end
        end
    end

    // line capture, held through ic_fill
    always_ff @(posedge clk) begin
        if (state == ic_wait_fill && l2_rdy) begin
            line_q <= l2_line;
        end
    end

endmodule

/* logic/icache_lru.sv */
/*
 instruction cache lru bits
 one bit per set naming the way to replace next
*/
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_lru (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`IC_INDEX_W-1:0] index,
    input  logic                   lru_upd,    // hit or fill this cycle
    input  logic                   lru_way,    // way just used
    output logic                   lru         // way to replace
);

    logic [`IC_SETS-1:0] lru_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_q <= '0;                        // every set points at way 0
        end else if (lru_upd) begin
            lru_q[index] <= ~lru_way;           // other way is now older
        end
    end

    assign lru = lru_q[index];  // async, read with the tags

endmodule

/* logic/icache_pkg.sv */
/*
 instruction cache types
 vector typedefs for words, lines, address fields and the miss fsm states
*/
`include "icache_consts.svh"

package icache_pkg;

    typedef logic [31:0] word_t;                              // instruction or address
    typedef logic [`IC_LINE_WORDS*32-1:0] line_t;             // word 0 in low bits
    typedef logic [`IC_TAG_W-1:0] tag_t;                      // addr tag
    typedef logic [`IC_INDEX_W-1:0] index_t;                  // set index
    typedef logic [1:0] offset_t;                             // word in line

    // miss handling fsm
    typedef enum logic [2:0] {
        ic_idle,        // one cycle after reset
        ic_lookup,      // tag compare, hit returns word
        ic_wait_busy,   // next level busy, hold request
        ic_wait_fill,   // request sent, wait for line
        ic_fill         // write victim way
    } ic_state_t;

endpackage

/* logic/icache_top.sv */
/*
 two-way set-associative instruction cache
 controller, two way arrays and lru bits between fetch and next level
*/
`timescale 1ns/100ps

module icache_top import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // fetch side
    input  word_t fetch_addr,
    output word_t fetch_data,
    output logic  data_rdy,
    output logic  miss_stall,
    // next level
    input  logic  l2_busy,
    output logic  l2_req,
    output word_t l2_addr,
    input  logic  l2_rdy,
    input  line_t l2_line
);

    index_t index;              // shared by both ways and lru
    tag_t   fill_tag;
    line_t  fill_line;
    logic   fill0, fill1;       // way write strobes
    logic   valid0, valid1;
    tag_t   tag0, tag1;
    line_t  line0, line1;
    logic   lru, lru_upd, lru_way;

    icache_ctrl ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .data_rdy   (data_rdy),
        .miss_stall (miss_stall),
        .l2_busy    (l2_busy),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr),
        .l2_rdy     (l2_rdy),
        .l2_line    (l2_line),
        .index      (index),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .fill0      (fill0),
        .fill1      (fill1),
        .valid0     (valid0),
        .valid1     (valid1),
        .tag0       (tag0),
        .tag1       (tag1),
        .line0      (line0),
        .line1      (line1),
        .lru        (lru),
        .lru_upd    (lru_upd),
        .lru_way    (lru_way)
    );

    // way 0
    icache_way way0 (
        .clk (clk), .rst_n (rst_n), .index (index), .fill (fill0),
        .fill_tag (fill_tag), .fill_line (fill_line),
        .valid (valid0), .tag (tag0), .line (line0)
    );

    // way 1
    icache_way way1 (
        .clk (clk), .rst_n (rst_n), .index (index), .fill (fill1),
        .fill_tag (fill_tag), .fill_line (fill_line),
        .valid (valid1), .tag (tag1), .line (line1)
    );

    icache_lru lru_bits (
        .clk (clk), .rst_n (rst_n), .index (index),
        .lru_upd (lru_upd), .lru_way (lru_way), .lru (lru)
    );

endmodule

/* logic/icache_way.sv */
/*
 instruction cache way storage
 valid bit, tag and line per set, async read by index, sync fill write
*/
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_way import icache_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  index_t index,       // set to read and to fill
    input  logic   fill,        // write strobe
    input  tag_t   fill_tag,
    input  line_t  fill_line,
    output logic   valid,
    output tag_t   tag,
    output line_t  line
);

    logic [`IC_SETS-1:0] valid_q;       // flat so reset clears in one cycle
    tag_t                tag_mem [`IC_SETS];
    line_t               line_mem [`IC_SETS];

    // valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;                  // all sets empty
        end else if (fill) begin
            valid_q[index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[index]  <= fill_tag;
            line_mem[index] <= fill_line;   // whole line in one write
        end
    end

    // async read
    // ctrl needs tag and data in the lookup cycle for zero latency hit
    assign valid = valid_q[index];
    assign tag   = tag_mem[index];
    assign line  = line_mem[index];

endmodule

/* testbench/icache_l2_model.sv */
/*
 next-level memory model for the instruction cache testbench
 random busy stretches, fixed read latency, lines built from the word pattern
*/
`timescale 1ns/100ps

module icache_l2_model import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  hold_busy,        // busy forced by the testbench
    input  logic  l2_req,
    input  word_t l2_addr,
    output logic  l2_busy,
    output logic  l2_rdy,
    output line_t l2_line
);

    localparam int LATENCY = 5;     // cycles from request to line

    integer seed;
    int     busy_left;
    int     wait_left;
    logic   pending;                // one miss in flight
    word_t  req_addr;
    logic   rst_seen, req_seen, hold_seen;
    word_t  addr_seen;
    word_t  r;

    // same pattern as the testbench reference
    function automatic word_t word_at(input word_t addr);
        return {addr[17:2], ~addr[31:16]} ^ 32'h3c1f_a7e5;
    endfunction

    function automatic line_t build_line(input word_t addr);
        line_t ln;
        for (int w = 0; w < 4; w++) begin
            ln[w*32 +: 32] = word_at({addr[31:4], w[1:0], 2'b00});  // word 0 low
        end
        return ln;
    endfunction

    initial begin
        seed      = 32'ha542;
        l2_busy   = 1'b0;
        l2_rdy    = 1'b0;
        l2_line   = '0;
        pending   = 1'b0;
        busy_left = 0;
        wait_left = 0;
        req_addr  = '0;
        forever begin
            @(negedge clk);                 // dut outputs settled here
            rst_seen  = rst_n;
            req_seen  = l2_req;
            addr_seen = l2_addr;
            hold_seen = hold_busy;
            @(posedge clk);
            #2;
            l2_rdy = 1'b0;                  // single cycle strobe
            if (!rst_seen) begin
                pending   = 1'b0;
                busy_left = 0;
                l2_busy   = 1'b0;
            end else begin
                if (req_seen && !pending) begin
                    pending   = 1'b1;
                    req_addr  = addr_seen;
                    wait_left = LATENCY;
                end
                if (pending) begin
                    wait_left--;
                    if (wait_left == 0) begin
                        pending = 1'b0;
                        l2_rdy  = 1'b1;
                        l2_line = build_line(req_addr);
                    end
                end
                // new busy stretch about one cycle in eight, 1 to 8 long
                if (busy_left == 0 && !hold_seen) begin
                    r = $random(seed);
                    if (r[2:0] == 3'd0) begin
                        busy_left = 1 + int'(r[6:4]);
                    end
                end
                l2_busy = hold_seen || (busy_left > 0);
                if (busy_left > 0) begin
                    busy_left--;
                end
            end
        end
    end

endmodule

/* testbench/icache_tb.sv */
/*
 instruction cache testbench
 directed and random fetches checked against a reference cache and word pattern
*/
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_tb import icache_pkg::*; ();

    localparam int TOTAL_FETCHES    = 319;     // 4 + 5 + 3 + 5 + 2 + 300
    localparam int CYCLES_PER_FETCH = 40;

    logic  clk, rst_n;
    word_t fetch_addr, fetch_data;
    logic  data_rdy, miss_stall;
    logic  l2_busy, l2_req, l2_rdy;
    word_t l2_addr;
    line_t l2_line;
    logic  hold_busy;               // pins l2_busy high in the model

    integer seed;
    int     errors, checks, tests_run, tests_failed, errors_at_start;
    int     reqs_seen;              // l2_req cycles since reset

    // reference cache state
    bit   ref_valid [2][`IC_SETS];
    tag_t ref_tag   [2][`IC_SETS];
    bit   ref_lru   [`IC_SETS];     // way to replace next
    tag_t tag_pool  [4] = '{20'h00023, 20'h00077, 20'h000cc, 20'h00f01};

    icache_top dut (
        .clk (clk), .rst_n (rst_n), .fetch_addr (fetch_addr), .fetch_data (fetch_data),
        .data_rdy (data_rdy), .miss_stall (miss_stall), .l2_busy (l2_busy),
        .l2_req (l2_req), .l2_addr (l2_addr), .l2_rdy (l2_rdy), .l2_line (l2_line)
    );

    icache_l2_model l2 (
        .clk (clk), .rst_n (rst_n), .hold_busy (hold_busy), .l2_req (l2_req),
        .l2_addr (l2_addr), .l2_busy (l2_busy), .l2_rdy (l2_rdy), .l2_line (l2_line)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    // expected instruction word at an address
    function automatic word_t mem_word(input word_t addr);
        return {addr[17:2], ~addr[31:16]} ^ 32'h3c1f_a7e5;
    endfunction

    // way holding addr in the reference or -1 on a miss
    function automatic int hit_way(input word_t addr);
        index_t idx;
        tag_t   tg;
        idx = addr[11:4];
        tg  = addr[31:12];
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tg) return w;
        end
        return -1;
    endfunction

    // hit updates lru and a miss fills empty way 0, then empty way 1, then the lru way
    task automatic ref_update(input word_t addr);
        index_t idx;
        int     way;
        idx = addr[11:4];
        way = hit_way(addr);
        if (way < 0) begin
            if (!ref_valid[0][idx]) way = 0;
            else if (!ref_valid[1][idx]) way = 1;
            else way = int'(ref_lru[idx]);
            ref_valid[way][idx] = 1'b1;
            ref_tag[way][idx]   = addr[31:12];
        end
        ref_lru[idx] = (way == 0);  // other way is older now
    endtask

    // one fetch entered and left 2 ns after a rising edge
    task automatic fetch(input word_t addr, input int busy_cycles);
        bit exp_hit;
        int reqs_before;
        exp_hit     = (hit_way(addr) >= 0);
        reqs_before = reqs_seen;
        fetch_addr  = addr;
        @(negedge clk);
        checks++;
        assert (data_rdy == exp_hit && miss_stall == !exp_hit) else begin
            errors++;
            $display("Error at %0t: fetch %h expected %s, data_rdy %b miss_stall %b",
                     $time, addr, exp_hit ? "hit" : "miss", data_rdy, miss_stall);
        end
        if (busy_cycles > 0) begin
            repeat (busy_cycles) begin
                @(negedge clk);
                checks++;
                assert (miss_stall && !l2_req) else begin
                    errors++;
                    $display("Error at %0t: request or stall drop while busy", $time);
                end
            end
            @(posedge clk);
            #2;
            hold_busy = 1'b0;
            @(negedge clk);
        end
        while (!data_rdy) begin
            assert (miss_stall) else begin
                errors++;
                $display("Error at %0t: miss_stall low before data_rdy", $time);
            end
            @(negedge clk);
        end
        ref_update(addr);
        @(posedge clk);
        #2;
        // one single cycle request per miss, none on a hit
        checks++;
        assert (reqs_seen - reqs_before == (exp_hit ? 0 : 1)) else begin
            errors++;
            $display("Error at %0t: fetch %h saw %0d request cycles, expected %0d",
                     $time, addr, reqs_seen - reqs_before, exp_hit ? 0 : 1);
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end
    endtask

    // data on every hit and address on every request
    always @(negedge clk) begin
        if (rst_n && data_rdy) begin
            checks++;
            assert (fetch_data == mem_word(fetch_addr) && !miss_stall) else begin
                errors++;
                $display("Error at %0t: addr %h data %h expected %h", $time,
                         fetch_addr, fetch_data, mem_word(fetch_addr));
            end
        end
        if (rst_n && l2_req) begin
            reqs_seen++;
            checks++;
            assert (l2_addr == (fetch_addr & 32'hffff_fff0) && !l2_busy) else begin
                errors++;
                $display("Error at %0t: l2_addr %h for fetch %h, busy %b", $time,
                         l2_addr, fetch_addr, l2_busy);
            end
        end
    end

    initial begin
        repeat (TOTAL_FETCHES * CYCLES_PER_FETCH) @(posedge clk);
        $display("timeout: fetches did not finish in %0d cycles",
                 TOTAL_FETCHES * CYCLES_PER_FETCH);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        word_t r;
        seed       = 32'ha542;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        tests_failed = 0;
        reqs_seen  = 0;
        rst_n      = 1'b0;
        fetch_addr = '0;
        hold_busy  = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);             // ic_idle cycle
        checks++;
        assert (!data_rdy && !miss_stall && !l2_req) else begin
            errors++;
            $display("Error at %0t: outputs active after reset", $time);
        end
        @(posedge clk);
        #2;

        start_test();
        for (int i = 0; i < 4; i++) fetch(32'h0010_0000 | (i << 4) | (i << 2), 0);
        end_test("cold fetch");

        start_test();
        fetch(32'h0002_3450, 0);
        for (int o = 0; o < 4; o++) fetch(32'h0002_3450 + 4 * o, 0);
        end_test("repeated hits");

        start_test();
        fetch(32'h0007_7450, 0);    // same set with way 1 still empty
        fetch(32'h0002_3458, 0);
        fetch(32'h0007_7454, 0);
        end_test("two-way fill");

        start_test();
        fetch(32'h000c_c45c, 0);    // third tag evicts the older line
        fetch(32'h0007_7450, 0);
        fetch(32'h0002_3450, 0);
        fetch(32'h000c_c45c, 0);
        fetch(32'h0007_7458, 0);
        end_test("lru replacement");

        start_test();
        hold_busy = 1'b1;
        @(posedge clk);
        #2;
        fetch(32'h0004_1880, 6);
        fetch(32'h0004_188c, 0);
        end_test("busy back-pressure");

        start_test();
        repeat (300) begin
            r = $random(seed);
            fetch({tag_pool[r[1:0]], 6'b010001, r[3:2], r[5:4], 2'b00}, 0);  // sets 0x44 to 0x47
        end
        end_test("random run");

        $display("tests %0d run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
